// ==== dv/au_chk.sv ====
// ------------------------------
// Protocol checks on the arithmetic unit top level
// Bound into au_top, watches the start handshake, write strobe and irq
// ------------------------------

`timescale 1ns/1ps

module au_chk (
  input logic clk,        // Clock
  input logic rst_n,      // Async reset, active low
  input logic start_req,  // Host start request
  input logic start_ack,  // Start acknowledge
  input logic exe_we,     // Internal result write strobe
  input logic sts_finish, // Finish flag
  input logic sts_error,  // Error flag
  input logic irq         // Interrupt
);

  int assert_fails = 0;   // Failure count, read by the testbench

  // Handshake ---------------------
  ack_rise_a : assert property (@(posedge clk) disable iff (!rst_n)
    $rose(start_ack) |-> $past(start_req))
    else begin
      $error("start_ack rose while start_req was low");
      assert_fails++;
    end

  ack_fall_a : assert property (@(posedge clk) disable iff (!rst_n)
    $fell(start_ack) |-> !$past(start_req))
    else begin
      $error("start_ack fell while start_req was still high");
      assert_fails++;
    end

  // Write strobe and interrupt ----
  we_pulse_a : assert property (@(posedge clk) disable iff (!rst_n)
    exe_we |=> !exe_we)
    else begin
      $error("exe_we high for two cycles");
      assert_fails++;
    end

  irq_or_a : assert property (@(posedge clk) disable iff (!rst_n)
    irq == (sts_finish | sts_error))
    else begin
      $error("irq differs from the OR of the status flags");
      assert_fails++;
    end

endmodule

bind au_top au_chk i_au_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .start_req  (start_req),
  .start_ack  (start_ack),
  .exe_we     (exe_we),
  .sts_finish (sts_finish),
  .sts_error  (sts_error),
  .irq        (irq)
);

// ==== dv/au_tb.sv ====
// ------------------------------
// Testbench for the arithmetic unit top level
// Table of instructions applied in a loop, results checked against a
// register model built from the opcode rules
// Inputs change on the falling edge, outputs are sampled in the low phase
// ------------------------------

`timescale 1ns/1ps

`include "au_config.svh"

module au_tb;

  localparam int clk_period      = 100;                   // ns
  localparam int hs_timeout      = 10;                    // Cycles per handshake phase
  localparam int num_tests       = 11;                    // Table entries
  localparam int test_cycles     = 20 + `AU_NUM_REGS;     // Handshake plus register sweep
  localparam int watchdog_cycles = (num_tests + 8) * test_cycles; // 8 extra for setup tests

  // One table row
  typedef struct packed {
    logic [`AU_OP_W-1:0] op;
    au_pkg::reg_addr_t   src0;
    au_pkg::reg_addr_t   src1;
    au_pkg::reg_addr_t   dest;
    au_pkg::imm_t        imm_val;
    logic                bad_op;  // Expect error flag instead of a write
  } instr_t;

  logic                clk;
  logic                rst_n;
  logic                host_we;
  au_pkg::reg_addr_t   host_addr;
  au_pkg::word_t       host_wdata;
  au_pkg::reg_addr_t   host_rd_addr;
  au_pkg::word_t       host_rd_data;
  logic                start_req;
  logic [`AU_OP_W-1:0] op_code;
  au_pkg::reg_addr_t   rs0;
  au_pkg::reg_addr_t   rs1;
  au_pkg::reg_addr_t   dst;
  au_pkg::imm_t        imm;
  logic                start_ack;
  logic                clr_finish;
  logic                clr_error;
  logic                sts_finish;
  logic                sts_error;
  logic                irq;

  instr_t        tests [num_tests];      // Stimulus table
  au_pkg::word_t model [`AU_NUM_REGS];   // Expected register contents
  logic [31:0]   lfsr;                   // Random state
  logic          exp_fin;                // Expected sts_finish
  logic          exp_err;                // Expected sts_error
  instr_t        ent;                    // Current row
  au_pkg::word_t exp_val;                // Expected result of current row
  au_pkg::word_t rnd;                    // Drawn operand
  int            test_errors;            // Errors in the running test
  int            tests_run;
  int            tests_passed;
  int            tests_failed;

  au_top i_au_top (.*);

  // Clock and watchdog ------------
  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  initial begin
    #(watchdog_cycles * clk_period);
    $display("Watchdog expired after %0d cycles, the run did not complete", watchdog_cycles);
    $display("Test failures found");
    $finish;
  end

  // Helpers -----------------------
  // Galois form, x^32 + x^31 + x^29 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  task draw_word(output au_pkg::word_t w);
    w = '0;
    for (int b = 0; b < `AU_DATA_W; b++) begin
      lfsr = lfsr_next(lfsr);           // One step per bit
      w    = {w[`AU_DATA_W-2:0], lfsr[0]};
    end
  endtask

  // Result per opcode rule, 64-bit products cut to 32 bits
  function automatic au_pkg::word_t expected_result(input logic [`AU_OP_W-1:0] op,
      input au_pkg::word_t a, input au_pkg::word_t b, input au_pkg::imm_t iv);
    logic [63:0]   wide;
    au_pkg::word_t imm_w;
    imm_w = {24'h0, iv};                // Zero extension
    wide  = '0;
    case (op)
      3'd0:    wide = {32'h0, a} + {32'h0, imm_w};
      3'd1:    wide = {32'h0, a} * {32'h0, imm_w};
      3'd2:    wide = {32'h0, a} + {32'h0, b};
      3'd3:    wide = {32'h0, a} * {32'h0, b};
      3'd4:    wide = {32'h0, a} * {32'h0, b} + {32'h0, imm_w};
      default: wide = '0;               // No write expected
    endcase
    expected_result = wide[31:0];
  endfunction

  task check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      test_errors++;
    end
  endtask

  task check_flags(input logic fin, input logic err);
    check_value("sts_finish", 32'(sts_finish), 32'(fin));
    check_value("sts_error", 32'(sts_error), 32'(err));
    check_value("irq", 32'(irq), 32'(fin | err));
  endtask

  // One register per cycle, sampled mid low phase
  task compare_registers();
    for (int r = 0; r < `AU_NUM_REGS; r++) begin
      @(negedge clk);
      host_rd_addr = au_pkg::reg_addr_t'(r);
      #(clk_period / 4);
      check_value($sformatf("register %0d", r), host_rd_data, model[r]);
    end
  endtask

  task host_write(input au_pkg::reg_addr_t addr, input au_pkg::word_t data);
    @(negedge clk);
    host_we    = 1'b1;
    host_addr  = addr;
    host_wdata = data;
    model[addr] = data;
  endtask

  task pulse_clear(input logic fin, input logic err);
    @(negedge clk);
    clr_finish = fin;
    clr_error  = err;
    @(negedge clk);                     // Flags updated at the edge between
    clr_finish = 1'b0;
    clr_error  = 1'b0;
  endtask

  // Four-phase start, returns at the negedge after start_ack falls
  task execute_instr(input logic [`AU_OP_W-1:0] opc, input au_pkg::reg_addr_t src0,
      input au_pkg::reg_addr_t src1, input au_pkg::reg_addr_t dest, input au_pkg::imm_t iv);
    int   cycles;
    logic seen;
    @(negedge clk);
    check_value("start_ack before request", 32'(start_ack), 32'd0);
    op_code   = opc;
    rs0       = src0;
    rs1       = src1;
    dst       = dest;
    imm       = iv;
    start_req = 1'b1;
    cycles    = 0;
    seen      = 1'b0;
    while (!seen && cycles < hs_timeout) begin
      @(negedge clk);
      cycles++;
      seen = start_ack;
    end
    if (!seen) begin
      $display("Handshake failure at %0t ns: start_ack never rose after start_req", $time);
      test_errors++;
    end else begin
      check_value("cycles to start_ack rise", 32'(cycles), 32'd1);
    end
    start_req = 1'b0;                   // Drop on first sight of ack
    cycles    = 0;
    seen      = 1'b1;
    while (seen && cycles < hs_timeout) begin
      @(negedge clk);
      cycles++;
      seen = start_ack;
    end
    if (seen) begin
      $display("Handshake failure at %0t ns: start_ack stayed high after start_req fell", $time);
      test_errors++;
    end else begin
      check_value("cycles to start_ack fall", 32'(cycles), 32'd1);
    end
  endtask

  task report_test(input string name);
    tests_run++;
    if (test_errors == 0) begin
      tests_passed++;
      $display("Test %0d %s: PASS", tests_run, name);
    end else begin
      tests_failed++;
      $display("Test %0d %s: FAIL with %0d errors", tests_run, name, test_errors);
    end
    test_errors = 0;
  endtask

  task load_table();
    // op, src0, src1, dest, imm, bad_op
    tests[0]  = {3'd0, 5'd1,  5'd0,  5'd10, 8'h5a, 1'b0};  // Add immediate
    tests[1]  = {3'd1, 5'd2,  5'd0,  5'd11, 8'hff, 1'b0};  // Multiply immediate
    tests[2]  = {3'd2, 5'd3,  5'd4,  5'd12, 8'h00, 1'b0};  // Add registers
    tests[3]  = {3'd3, 5'd30, 5'd31, 5'd13, 8'h00, 1'b0};  // Overflowing product
    tests[4]  = {3'd4, 5'd5,  5'd6,  5'd14, 8'h80, 1'b0};  // Multiply-add
    tests[5]  = {3'd0, 5'd7,  5'd0,  5'd7,  8'h01, 1'b0};  // dst equals rs0
    tests[6]  = {3'd5, 5'd1,  5'd2,  5'd15, 8'h11, 1'b1};  // Illegal opcodes
    tests[7]  = {3'd6, 5'd3,  5'd4,  5'd16, 8'h22, 1'b1};
    tests[8]  = {3'd7, 5'd5,  5'd6,  5'd17, 8'h33, 1'b1};
    tests[9]  = {3'd3, 5'd8,  5'd8,  5'd8,  8'h00, 1'b0};  // Square into itself
    tests[10] = {3'd4, 5'd10, 5'd11, 5'd9,  8'h33, 1'b0};  // Uses earlier results
  endtask

  // Main sequence -----------------
  initial begin
    rst_n        = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    host_rd_addr = '0;
    start_req    = 1'b0;
    op_code      = '0;
    rs0          = '0;
    rs1          = '0;
    dst          = '0;
    imm          = '0;
    clr_finish   = 1'b0;
    clr_error    = 1'b0;
    lfsr         = 32'd77473;
    exp_fin      = 1'b0;
    exp_err      = 1'b0;
    test_errors  = 0;
    tests_run    = 0;
    tests_passed = 0;
    tests_failed = 0;
    for (int r = 0; r < `AU_NUM_REGS; r++) model[r] = '0;
    load_table();
    repeat (4) @(negedge clk);
    rst_n = 1'b1;

    // Reset values
    check_value("start_ack after reset", 32'(start_ack), 32'd0);
    check_flags(1'b0, 1'b0);
    compare_registers();
    report_test("reset state");

    // Random fill, then fixed large operands for the overflow row
    for (int r = 0; r < `AU_NUM_REGS; r++) begin
      draw_word(rnd);
      host_write(au_pkg::reg_addr_t'(r), rnd);
    end
    host_write(5'd30, 32'hDEAD_BEEF);
    host_write(5'd31, 32'hCAFE_F00D);
    @(negedge clk);
    host_we = 1'b0;
    compare_registers();
    report_test("host write readback");

    // Instruction table
    for (int t = 0; t < num_tests; t++) begin
      ent     = tests[t];
      exp_val = expected_result(ent.op, model[ent.src0], model[ent.src1], ent.imm_val);
      execute_instr(ent.op, ent.src0, ent.src1, ent.dest, ent.imm_val);
      if (ent.bad_op) begin
        exp_err = 1'b1;                 // Register file untouched
      end else begin
        exp_fin         = 1'b1;
        model[ent.dest] = exp_val;
      end
      check_flags(exp_fin, exp_err);
      compare_registers();
      report_test($sformatf("opcode %0d into r%0d", ent.op, ent.dest));
    end

    // Separate clears
    pulse_clear(1'b1, 1'b0);
    check_flags(1'b0, 1'b1);
    report_test("clear finish only");
    pulse_clear(1'b0, 1'b1);
    check_flags(1'b0, 1'b0);
    report_test("clear error only");

    execute_instr(3'd5, 5'd1, 5'd2, 5'd3, 8'h44);
    check_flags(1'b0, 1'b1);
    compare_registers();
    report_test("illegal opcode leaves finish low");

    exp_val = expected_result(3'd2, model[1], model[2], 8'h00);
    execute_instr(3'd2, 5'd1, 5'd2, 5'd4, 8'h00);
    model[4] = exp_val;
    check_flags(1'b1, 1'b1);
    pulse_clear(1'b0, 1'b1);
    check_flags(1'b1, 1'b0);
    pulse_clear(1'b1, 1'b0);
    check_flags(1'b0, 1'b0);
    compare_registers();
    report_test("clear error keeps finish");

    if (i_au_top.i_au_chk.assert_fails != 0) begin
      $display("Bound checker saw %0d assertion failures", i_au_top.i_au_chk.assert_fails);
      tests_failed++;
    end
    $display("Tests run %0d, passed %0d, failed %0d", tests_run, tests_passed, tests_failed);
    if (tests_failed == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+source
source/au_pkg.sv
source/au_work_regs.sv
source/au_exec.sv
source/au_irq_status.sv
source/au_top.sv
dv/au_chk.sv
dv/au_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the arithmetic unit testbench with Verilator and runs it.
# The result is taken from the simulation log.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
  -f files.f \
  --top-module au_tb \
  -o Vau_tb

# Keep running past assertion errors so the testbench can report them
./obj_dir/Vau_tb +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "All tests passed!" sim.log; then
  echo "Simulation result: pass"
  exit 0
else
  echo "Simulation result: fail"
  exit 1
fi

// ==== source/au_config.svh ====
// ------------------------------
// Sizes of the arithmetic unit
// Included by the package, the RTL and the testbench
// Every width in the design is derived from these values
// ------------------------------

`ifndef AU_CONFIG_SVH
`define AU_CONFIG_SVH

// Datapath ----------------------
`define AU_DATA_W   32  // Work register width

// Register file -----------------
`define AU_NUM_REGS 32  // Number of work registers
`define AU_ADDR_W   5   // Register index width

// Instruction fields ------------
`define AU_IMM_W    8   // Immediate width, zero-extended
`define AU_OP_W     3   // Opcode width

`endif

// ==== source/au_exec.sv ====
// ------------------------------
// Execute unit of the arithmetic unit
// Decodes one instruction per four-phase start_req/start_ack cycle
// Result and write strobe are registered at the accepting edge
// done_ok or done_err pulses one cycle for the status block
// ------------------------------

`timescale 1ns/1ps

`include "au_config.svh"

module au_exec (
  input  logic                clk,       // Clock
  input  logic                rst_n,     // Async reset, active low
  // Start handshake
  input  logic                start_req, // Host start request
  output logic                start_ack, // Start acknowledge
  // Instruction fields
  input  logic [`AU_OP_W-1:0] op_code,   // Raw opcode
  input  au_pkg::word_t       rs0_data,  // Operand 0 value
  input  au_pkg::word_t       rs1_data,  // Operand 1 value
  input  au_pkg::reg_addr_t   dst,       // Destination index
  input  au_pkg::imm_t        imm,       // Immediate
  // Register file write
  output logic                exe_we,    // One-cycle write strobe
  output au_pkg::reg_addr_t   exe_addr,  // Destination index
  output au_pkg::word_t       exe_wdata, // Result value
  // Status pulses
  output logic                done_ok,   // Valid instruction done
  output logic                done_err   // Illegal opcode seen
);

  au_pkg::op_e   op;          // Decoded opcode
  logic          op_valid;    // Opcode in legal range
  logic          mul_by_reg;  // Multiplier takes rs1 instead of imm
  logic          add_reg;     // Adder takes rs1 instead of imm
  logic          add_prod;    // Adder takes the product instead of rs0
  logic          res_prod;    // Result is the bare product
  logic          start_acc;   // Request accepted this cycle
  au_pkg::word_t imm_ext;     // Zero-extended immediate
  au_pkg::word_t mul_b;       // Second multiplier operand
  au_pkg::word_t mul_p;       // Product, truncated
  au_pkg::word_t add_a;       // First adder operand
  au_pkg::word_t add_b;       // Second adder operand
  au_pkg::word_t add_s;       // Sum, truncated
  au_pkg::word_t result;      // Value for the destination

  // Decode ------------------------
  assign op = au_pkg::op_e'(op_code);

  always_comb begin
    op_valid   = 1'b1;
    mul_by_reg = 1'b0;
    add_reg    = 1'b0;
    add_prod   = 1'b0;
    res_prod   = 1'b0;
    case (op)
      au_pkg::op_add_imm: add_reg    = 1'b0;  // rs0 + imm
      au_pkg::op_mul_imm: res_prod   = 1'b1;  // rs0 * imm
      au_pkg::op_add_reg: add_reg    = 1'b1;  // rs0 + rs1
      au_pkg::op_mul_reg: begin               // rs0 * rs1
        mul_by_reg = 1'b1;
        res_prod   = 1'b1;
      end
      au_pkg::op_mac_imm: begin               // rs0 * rs1 + imm
        mul_by_reg = 1'b1;
        add_prod   = 1'b1;
      end
      default:            op_valid   = 1'b0;  // Codes 5 to 7
    endcase
  end

  // Datapath ----------------------
  assign imm_ext = {{(`AU_DATA_W-`AU_IMM_W){1'b0}}, imm};
  assign mul_b   = mul_by_reg ? rs1_data : imm_ext;
  assign mul_p   = rs0_data * mul_b;              // Upper product bits dropped
  assign add_a   = add_prod ? mul_p : rs0_data;
  assign add_b   = add_reg ? rs1_data : imm_ext;
  assign add_s   = add_a + add_b;                 // Carry out dropped
  assign result  = res_prod ? mul_p : add_s;

  // Handshake and control ---------
  assign start_acc = start_req & ~start_ack;      // New request, previous one returned

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      start_ack <= 1'b0;
      exe_we    <= 1'b0;
      done_ok   <= 1'b0;
      done_err  <= 1'b0;
    end else begin
      exe_we   <= start_acc & op_valid;          // Single-cycle pulses
      done_ok  <= start_acc & op_valid;
      done_err <= start_acc & ~op_valid;         // No write on illegal opcode
      if (start_acc) begin
        start_ack <= 1'b1;
      end else if (!start_req) begin
        start_ack <= 1'b0;                       // Return to idle
      end
    end
  end

  // Write payload, held until the next accepted instruction
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      exe_addr  <= '0;
      exe_wdata <= '0;
    end else if (start_acc && op_valid) begin
      exe_addr  <= dst;
      exe_wdata <= result;
    end
  end

endmodule

// ==== source/au_irq_status.sv ====
// ------------------------------
// Sticky status flags and interrupt line
// Set by the execute done pulses, cleared by the host
// A set in the same cycle as a clear wins
// ------------------------------

`timescale 1ns/1ps

module au_irq_status (
  input  logic clk,        // Clock
  input  logic rst_n,      // Async reset, active low
  input  logic done_ok,    // Valid instruction done
  input  logic done_err,   // Illegal opcode seen
  input  logic clr_finish, // Host clear of sts_finish
  input  logic clr_error,  // Host clear of sts_error
  output logic sts_finish, // Sticky finish flag
  output logic sts_error,  // Sticky error flag
  output logic irq         // Interrupt level
);

  // Flags -------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sts_finish <= 1'b0;
      sts_error  <= 1'b0;
    end else begin
      if (done_ok) begin
        sts_finish <= 1'b1;              // Set has priority
      end else if (clr_finish) begin
        sts_finish <= 1'b0;
      end
      if (done_err) begin
        sts_error <= 1'b1;
      end else if (clr_error) begin
        sts_error <= 1'b0;
      end
    end
  end

  assign irq = sts_finish | sts_error;  // Level, no extra latency

endmodule

// ==== source/au_pkg.sv ====
// ------------------------------
// Shared types of the arithmetic unit
// Referenced by scoped names, e.g. au_pkg::word_t
// ------------------------------

package au_pkg;

`include "au_config.svh"

  // Data and index types ----------
  typedef logic [`AU_DATA_W-1:0] word_t;     // One work register word
  typedef logic [`AU_ADDR_W-1:0] reg_addr_t; // Work register index
  typedef logic [`AU_IMM_W-1:0]  imm_t;      // Unsigned immediate

  // Opcodes -----------------------
  // Codes above op_mac_imm are illegal and raise the error flag
  typedef enum logic [`AU_OP_W-1:0] {
    op_add_imm = 3'd0,  // dst = rs0 + imm
    op_mul_imm = 3'd1,  // dst = rs0 * imm
    op_add_reg = 3'd2,  // dst = rs0 + rs1
    op_mul_reg = 3'd3,  // dst = rs0 * rs1
    op_mac_imm = 3'd4   // dst = rs0 * rs1 + imm
  } op_e;

endpackage

// ==== source/au_top.sv ====
// ------------------------------
// Top level of the arithmetic unit
// Host register port, start handshake and status flags
// Connects register file, execute unit and status block
// ------------------------------

`timescale 1ns/1ps

`include "au_config.svh"

module au_top (
  input  logic                clk,          // Clock
  input  logic                rst_n,        // Async reset, active low
  // Host register port
  input  logic                host_we,      // Host write strobe
  input  au_pkg::reg_addr_t   host_addr,    // Host write index
  input  au_pkg::word_t       host_wdata,   // Host write value
  input  au_pkg::reg_addr_t   host_rd_addr, // Host read index
  output au_pkg::word_t       host_rd_data, // Host read value
  // Instruction and handshake
  input  logic                start_req,    // Start request
  input  logic [`AU_OP_W-1:0] op_code,      // Opcode
  input  au_pkg::reg_addr_t   rs0,          // Source 0 index
  input  au_pkg::reg_addr_t   rs1,          // Source 1 index
  input  au_pkg::reg_addr_t   dst,          // Destination index
  input  au_pkg::imm_t        imm,          // Immediate
  output logic                start_ack,    // Start acknowledge
  // Status
  input  logic                clr_finish,   // Clear finish flag
  input  logic                clr_error,    // Clear error flag
  output logic                sts_finish,   // Finish flag
  output logic                sts_error,    // Error flag
  output logic                irq           // Interrupt
);

  au_pkg::word_t     rs0_data;  // Operand 0 from register file
  au_pkg::word_t     rs1_data;  // Operand 1 from register file
  logic              exe_we;    // Result write strobe
  au_pkg::reg_addr_t exe_addr;  // Result index
  au_pkg::word_t     exe_wdata; // Result value
  logic              done_ok;   // Finish pulse
  logic              done_err;  // Error pulse

  // Register file -----------------
  au_work_regs i_work_regs (
    .clk          (clk),
    .rst_n        (rst_n),
    .rs0_addr     (rs0),
    .rs1_addr     (rs1),
    .host_rd_addr (host_rd_addr),
    .rs0_data     (rs0_data),
    .rs1_data     (rs1_data),
    .host_rd_data (host_rd_data),
    .exe_we       (exe_we),
    .exe_addr     (exe_addr),
    .exe_wdata    (exe_wdata),
    .host_we      (host_we),
    .host_addr    (host_addr),
    .host_wdata   (host_wdata)
  );

  // Execute -----------------------
  au_exec i_exec (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_req (start_req),
    .start_ack (start_ack),
    .op_code   (op_code),
    .rs0_data  (rs0_data),
    .rs1_data  (rs1_data),
    .dst       (dst),
    .imm       (imm),
    .exe_we    (exe_we),
    .exe_addr  (exe_addr),
    .exe_wdata (exe_wdata),
    .done_ok   (done_ok),
    .done_err  (done_err)
  );

  // Status ------------------------
  au_irq_status i_irq_status (
    .clk        (clk),
    .rst_n      (rst_n),
    .done_ok    (done_ok),
    .done_err   (done_err),
    .clr_finish (clr_finish),
    .clr_error  (clr_error),
    .sts_finish (sts_finish),
    .sts_error  (sts_error),
    .irq        (irq)
  );

endmodule

// ==== source/au_work_regs.sv ====
// ------------------------------
// Work register file of the arithmetic unit
// Two operand read ports and one host read port, all combinational
// One write per cycle, the execute write wins over the host write
// ------------------------------

`timescale 1ns/1ps

`include "au_config.svh"

module au_work_regs (
  input  logic              clk,          // Clock
  input  logic              rst_n,        // Async reset, active low
  // Read ports
  input  au_pkg::reg_addr_t rs0_addr,     // Operand 0 index
  input  au_pkg::reg_addr_t rs1_addr,     // Operand 1 index
  input  au_pkg::reg_addr_t host_rd_addr, // Host read index
  output au_pkg::word_t     rs0_data,     // Operand 0 value
  output au_pkg::word_t     rs1_data,     // Operand 1 value
  output au_pkg::word_t     host_rd_data, // Host read value
  // Execute write port
  input  logic              exe_we,       // Result write strobe
  input  au_pkg::reg_addr_t exe_addr,     // Result index
  input  au_pkg::word_t     exe_wdata,    // Result value
  // Host write port
  input  logic              host_we,      // Host write strobe
  input  au_pkg::reg_addr_t host_addr,    // Host write index
  input  au_pkg::word_t     host_wdata    // Host write value
);

  au_pkg::word_t     regs [`AU_NUM_REGS]; // Register array
  logic              wr_en;               // Any write this cycle
  au_pkg::reg_addr_t wr_addr;             // Selected write index
  au_pkg::word_t     wr_data;             // Selected write value

  // Write select ------------------
  assign wr_en   = exe_we | host_we;
  assign wr_addr = exe_we ? exe_addr  : host_addr;  // Execute has priority
  assign wr_data = exe_we ? exe_wdata : host_wdata; // Host write dropped on conflict

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `AU_NUM_REGS; i++) begin
        regs[i] <= '0;                     // All registers start at zero
      end
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // Read ports --------------------
  assign rs0_data     = regs[rs0_addr];     // Feeds the execute datapath
  assign rs1_data     = regs[rs1_addr];
  assign host_rd_data = regs[host_rd_addr]; // Readback for the host

endmodule
